//--- src/cache_geom_pkg.sv
package cache_geom_pkg;

    // Address and word widths
    localparam int ADDR_WIDTH    = 32;
    localparam int DATA_WIDTH    = 32;

    // Cache organisation, one 32-bit word per line
    localparam int NUM_SETS      = 256;
    localparam int NUM_WAYS      = 8;
    localparam int WAY_BITS      = $clog2(NUM_WAYS);   // Way index width

    // Byte address split
    localparam int OFFSET_BITS   = 2;                  // Byte within word
    localparam int INDEX_BITS    = 8;                  // Set select
    localparam int TAG_BITS      = ADDR_WIDTH - INDEX_BITS - OFFSET_BITS;

    // LRU age counters, one per way
    localparam int AGE_BITS      = 3;
    localparam int AGE_MAX       = 7;                  // Saturation point

    // Backing memory, word addressed
    localparam int MEM_WORDS     = 4096;
    localparam int MEM_ADDR_BITS = 12;

    // 256 sets x 8 ways x 4 bytes = 8 KB of data

endpackage

//--- src/mem_access_pkg.sv
package mem_access_pkg;

    // Byte-enable code of an access, bit n enables byte lane n
    typedef logic [3:0] size_code_t;

    // Only these three codes are legal
    localparam size_code_t SIZE_BYTE = 4'b0001;   // Low byte
    localparam size_code_t SIZE_HALF = 4'b0011;   // Low halfword
    localparam size_code_t SIZE_WORD = 4'b1111;   // Full word

    // Cache view of a byte address
    typedef struct packed {
        logic [cache_geom_pkg::TAG_BITS-1:0]    tag;     // Compared per way
        logic [cache_geom_pkg::INDEX_BITS-1:0]  index;   // Set select
        logic [cache_geom_pkg::OFFSET_BITS-1:0] offset;  // Ignored by the cache
    } addr_fields_t;

    // Same 32 bits, read either as a plain address or split for lookup
    typedef union packed {
        logic [cache_geom_pkg::ADDR_WIDTH-1:0] raw;      // Byte address
        addr_fields_t                          fields;   // tag | index | offset
    } access_addr_u;

    // Layout of the fields view
    //   [31:10] tag
    //   [9:2]   set index
    //   [1:0]   byte offset

endpackage

//--- src/lru_age_tracker.sv
module lru_age_tracker (
    input  logic                                clk,
    input  logic                                reset_i,
    input  logic [cache_geom_pkg::INDEX_BITS-1:0] set_i,       // Set being looked at
    input  logic                                use_i,       // Way touched this cycle
    input  logic [cache_geom_pkg::WAY_BITS-1:0]   use_way_i,   // Which way
    output logic [cache_geom_pkg::WAY_BITS-1:0]   victim_way_o // Oldest way of set_i
);

    import cache_geom_pkg::*;

    // Flat age registers, all cleared in the reset cycle
    logic [AGE_BITS-1:0] age_q [NUM_SETS][NUM_WAYS];

    // Running maximum for the victim search
    logic [AGE_BITS-1:0] oldest_age;

    // Age update on use
    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                for (int w = 0; w < NUM_WAYS; w++) begin
                    age_q[s][w] <= '0;
                end
            end
        end else if (use_i) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                if (WAY_BITS'(w) == use_way_i) begin
                    age_q[set_i][w] <= '0;                       // Most recent
                end else if (age_q[set_i][w] < AGE_BITS'(AGE_MAX)) begin
                    age_q[set_i][w] <= age_q[set_i][w] + 1'b1;   // Grows older
                end
                // Saturated ways hold at AGE_MAX
            end
        end
    end

    // Victim search
    // Strict compare keeps the lowest way on ties, so an empty set
    // after reset is filled from way 0 upward
    always_comb begin
        victim_way_o = '0;
        oldest_age   = age_q[set_i][0];
        for (int w = 1; w < NUM_WAYS; w++) begin
            if (age_q[set_i][w] > oldest_age) begin
                oldest_age   = age_q[set_i][w];
                victim_way_o = WAY_BITS'(w);
            end
        end
    end

    // With 8 ways and a 3-bit counter, a full set after eight fills
    // holds ages 7,6,...,0 in ways 0..7, so way 0 goes first

endmodule

//--- src/l3_set_assoc_cache.sv
module l3_set_assoc_cache (
    input  logic                                  clk,
    input  logic                                  reset_i,
    // Requester side
    input  logic                                  req_i,       // One-cycle strobe
    input  logic                                  wr_i,
    input  mem_access_pkg::size_code_t            size_i,
    input  logic [cache_geom_pkg::ADDR_WIDTH-1:0] addr_i,
    input  logic [cache_geom_pkg::DATA_WIDTH-1:0] wdata_i,
    output logic                                  done_o,
    output logic                                  hit_o,
    output logic                                  err_o,
    output logic [cache_geom_pkg::DATA_WIDTH-1:0] rdata_o,
    output logic                                  busy_o,
    // Backing memory side
    output logic                                  mem_rd_o,
    output logic                                  mem_wr_o,
    output logic [cache_geom_pkg::ADDR_WIDTH-1:0] mem_addr_o,  // Byte address
    output mem_access_pkg::size_code_t            mem_be_o,
    output logic [cache_geom_pkg::DATA_WIDTH-1:0] mem_wdata_o,
    input  logic [cache_geom_pkg::DATA_WIDTH-1:0] mem_rdata_i  // One cycle after mem_rd_o
);

    import cache_geom_pkg::*;
    import mem_access_pkg::*;

    // Line storage, no reset on tags and data
    logic [TAG_BITS-1:0]   tag_mem  [NUM_SETS][NUM_WAYS];
    logic [DATA_WIDTH-1:0] data_mem [NUM_SETS][NUM_WAYS];
    logic [NUM_WAYS-1:0]   valid_q  [NUM_SETS];

    // Lookup of the incoming request
    access_addr_u          cur_addr;
    logic [NUM_WAYS-1:0]   way_hit;
    logic [WAY_BITS-1:0]   hit_way;
    logic [DATA_WIDTH-1:0] hit_line;
    logic                  size_ok;
    logic                  hit_acc;    // Accepted and hit
    logic                  miss_acc;   // Accepted and missed

    // Miss bookkeeping
    logic                  fill_q;     // Memory word arrives this cycle
    access_addr_u          req_q;      // Latched miss request
    logic                  wr_q;
    size_code_t            size_q;
    logic [DATA_WIDTH-1:0] wdata_q;
    logic [DATA_WIDTH-1:0] fill_word;

    // Completion registers
    logic                  done_q, hit_q, err_q, busy_q;
    logic [DATA_WIDTH-1:0] rdata_q;

    // Replacement interface
    logic [INDEX_BITS-1:0] lru_set;
    logic                  lru_use;
    logic [WAY_BITS-1:0]   lru_way;
    logic [WAY_BITS-1:0]   victim_way;

    // Zero-extended read of the low byte, halfword or whole word
    function automatic logic [DATA_WIDTH-1:0] size_select(input logic [DATA_WIDTH-1:0] word,
                                                          input size_code_t size);
        case (size)
            SIZE_BYTE: return {{(DATA_WIDTH-8){1'b0}}, word[7:0]};
            SIZE_HALF: return {{(DATA_WIDTH-16){1'b0}}, word[15:0]};
            default:   return word;
        endcase
    endfunction

    // Byte-lane merge under the enable code
    function automatic logic [DATA_WIDTH-1:0] merge_bytes(input logic [DATA_WIDTH-1:0] old_word,
                                                          input logic [DATA_WIDTH-1:0] new_word,
                                                          input size_code_t be);
        logic [DATA_WIDTH-1:0] result;
        result = old_word;
        for (int b = 0; b < DATA_WIDTH/8; b++) begin
            if (be[b]) result[8*b +: 8] = new_word[8*b +: 8];
        end
        return result;
    endfunction

    assign cur_addr = addr_i;
    assign size_ok  = (size_i == SIZE_BYTE) || (size_i == SIZE_HALF) || (size_i == SIZE_WORD);

    // Compare all eight ways of the set
    always_comb begin
        hit_way = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            way_hit[w] = valid_q[cur_addr.fields.index][w] &&
                         (tag_mem[cur_addr.fields.index][w] == cur_addr.fields.tag);
            if (way_hit[w]) hit_way = WAY_BITS'(w);
        end
    end

    assign hit_line = data_mem[cur_addr.fields.index][hit_way];
    assign hit_acc  = !fill_q && req_i && size_ok && (|way_hit);
    assign miss_acc = !fill_q && req_i && size_ok && !(|way_hit);

    // Miss write lands on top of the memory word
    assign fill_word = wr_q ? merge_bytes(mem_rdata_i, wdata_q, size_q) : mem_rdata_i;

    // LRU sees the latched set while filling
    assign lru_set = fill_q ? req_q.fields.index : cur_addr.fields.index;
    assign lru_use = hit_acc || fill_q;
    assign lru_way = fill_q ? victim_way : hit_way;

    lru_age_tracker u_lru (
        .clk          (clk),
        .reset_i      (reset_i),
        .set_i        (lru_set),
        .use_i        (lru_use),
        .use_way_i    (lru_way),
        .victim_way_o (victim_way)
    );

    // Control state
    always_ff @(posedge clk) begin
        if (reset_i) begin
            fill_q <= 1'b0;
            done_q <= 1'b0;
            hit_q  <= 1'b0;
            err_q  <= 1'b0;
            busy_q <= 1'b0;
        end else begin
            done_q <= 1'b0;                                  // Pulses by default
            hit_q  <= 1'b0;
            err_q  <= !fill_q && req_i && !size_ok;          // Bad size, nothing else moves
            if (done_q) busy_q <= 1'b0;                       // Drops after completion
            if (hit_acc) begin
                done_q <= 1'b1;
                hit_q  <= 1'b1;
                busy_q <= 1'b1;
            end
            if (miss_acc) begin
                fill_q <= 1'b1;
                busy_q <= 1'b1;
            end
            if (fill_q) begin
                fill_q <= 1'b0;
                done_q <= 1'b1;                               // T+2 completion
            end
        end
    end

    // Valid bits
    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int s = 0; s < NUM_SETS; s++) valid_q[s] <= '0;
        end else if (fill_q) begin
            valid_q[req_q.fields.index][victim_way] <= 1'b1;
        end
    end

    // Arrays and payload
    always_ff @(posedge clk) begin
        if (hit_acc) begin
            rdata_q <= size_select(hit_line, size_i);
            if (wr_i) data_mem[cur_addr.fields.index][hit_way] <= merge_bytes(hit_line, wdata_i, size_i);
        end
        if (miss_acc) begin
            req_q   <= cur_addr;
            wr_q    <= wr_i;
            size_q  <= size_i;
            wdata_q <= wdata_i;
        end
        if (fill_q) begin
            tag_mem[req_q.fields.index][victim_way]  <= req_q.fields.tag;
            data_mem[req_q.fields.index][victim_way] <= fill_word;
            rdata_q <= size_select(fill_word, size_q);
        end
    end

    // Memory port, write-through on every write
    assign mem_rd_o    = miss_acc;
    assign mem_wr_o    = (hit_acc && wr_i) || (fill_q && wr_q);   // Miss write after the read
    assign mem_addr_o  = fill_q ? req_q.raw : addr_i;
    assign mem_be_o    = fill_q ? size_q : size_i;
    assign mem_wdata_o = fill_q ? wdata_q : wdata_i;

    assign done_o  = done_q;
    assign hit_o   = hit_q;
    assign err_o   = err_q;
    assign rdata_o = rdata_q;
    assign busy_o  = busy_q;

endmodule

//--- src/main_memory.sv
module main_memory (
    input  logic                                     clk,
    input  logic                                     rd_i,
    input  logic                                     wr_i,
    input  logic [cache_geom_pkg::MEM_ADDR_BITS-1:0] addr_i,    // Word address
    input  logic [cache_geom_pkg::DATA_WIDTH/8-1:0]  be_i,      // Byte lanes to write
    input  logic [cache_geom_pkg::DATA_WIDTH-1:0]    wdata_i,
    output logic [cache_geom_pkg::DATA_WIDTH-1:0]    rdata_o    // Valid the cycle after rd_i
);

    import cache_geom_pkg::*;

    // Word array
    logic [DATA_WIDTH-1:0] mem_q [MEM_WORDS];

    // Power-up contents zero
    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem_q[i] = '0;
        end
    end

    // Byte-enabled write
    always_ff @(posedge clk) begin
        if (wr_i) begin
            for (int b = 0; b < DATA_WIDTH/8; b++) begin
                if (be_i[b]) begin
                    mem_q[addr_i][8*b +: 8] <= wdata_i[8*b +: 8];   // One lane
                end
            end
        end
    end

    // Registered read
    // Holds its last value when rd_i is low
    always_ff @(posedge clk) begin
        if (rd_i) begin
            rdata_o <= mem_q[addr_i];
        end
    end

    // The address port is MEM_ADDR_BITS wide, so higher address bits
    // never reach here and the array aliases every MEM_WORDS words

endmodule

//--- src/l3_mem_subsystem.sv
module l3_mem_subsystem (
    input  logic                                  clk,
    input  logic                                  reset_i,
    input  logic                                  req_i,
    input  logic                                  wr_i,
    input  mem_access_pkg::size_code_t            size_i,
    input  logic [cache_geom_pkg::ADDR_WIDTH-1:0] addr_i,
    input  logic [cache_geom_pkg::DATA_WIDTH-1:0] wdata_i,
    output logic                                  done_o,
    output logic                                  hit_o,
    output logic                                  err_o,
    output logic [cache_geom_pkg::DATA_WIDTH-1:0] rdata_o,
    output logic                                  busy_o
);

    import cache_geom_pkg::*;
    import mem_access_pkg::*;

    // Cache to memory
    logic                     mem_rd;
    logic                     mem_wr;
    access_addr_u             mem_addr;       // Byte address from the cache
    size_code_t               mem_be;
    logic [DATA_WIDTH-1:0]    mem_wdata;
    logic [DATA_WIDTH-1:0]    mem_rdata;
    logic [MEM_ADDR_BITS-1:0] mem_word_addr;

    l3_set_assoc_cache u_cache (
        .clk         (clk),
        .reset_i     (reset_i),
        .req_i       (req_i),
        .wr_i        (wr_i),
        .size_i      (size_i),
        .addr_i      (addr_i),
        .wdata_i     (wdata_i),
        .done_o      (done_o),
        .hit_o       (hit_o),
        .err_o       (err_o),
        .rdata_o     (rdata_o),
        .busy_o      (busy_o),
        .mem_rd_o    (mem_rd),
        .mem_wr_o    (mem_wr),
        .mem_addr_o  (mem_addr),
        .mem_be_o    (mem_be),
        .mem_wdata_o (mem_wdata),
        .mem_rdata_i (mem_rdata)
    );

    // Drop the byte offset, keep the low word bits
    assign mem_word_addr = mem_addr.raw[OFFSET_BITS +: MEM_ADDR_BITS];

    main_memory u_mem (
        .clk     (clk),
        .rd_i    (mem_rd),
        .wr_i    (mem_wr),
        .addr_i  (mem_word_addr),
        .be_i    (mem_be),
        .wdata_i (mem_wdata),
        .rdata_o (mem_rdata)
    );

endmodule

//--- tb/l3_cache_chk.sv
module l3_cache_chk (
    input logic clk,
    input logic reset_i,
    input logic req_i,
    input logic busy_i,
    input logic done_i,
    input logic err_i,
    input logic hit_i,
    input logic hit_acc_i,    // Accepted request that hit
    input logic mem_rd_i,
    input logic fill_i        // Memory word consumed this cycle
);

    // Failed assertions so far, watched from the testbench top
    int unsigned fail_count = 0;

    // Completion and error are exclusive
    done_err_excl: assert property (@(posedge clk) disable iff (reset_i) !(done_i && err_i))
        else begin
            fail_count++;
            $error("done and err pulsed in the same cycle");
        end

    // Hit answers in the next cycle
    hit_latency: assert property (@(posedge clk) disable iff (reset_i)
        hit_acc_i |=> (done_i && hit_i))
        else begin
            fail_count++;
            $error("hit did not complete one cycle after the request");
        end

    // Read data taken exactly one cycle after the memory read
    rd_to_fill: assert property (@(posedge clk) disable iff (reset_i) mem_rd_i |=> fill_i)
        else begin
            fail_count++;
            $error("memory read not followed by a fill");
        end

    fill_from_rd: assert property (@(posedge clk) disable iff (reset_i)
        fill_i |-> $past(mem_rd_i))
        else begin
            fail_count++;
            $error("fill without a memory read in the cycle before");
        end

    // Requester honours busy
    no_req_busy: assert property (@(posedge clk) disable iff (reset_i) req_i |-> !busy_i)
        else begin
            fail_count++;
            $error("request strobe while busy");
        end

endmodule

bind l3_set_assoc_cache l3_cache_chk u_chk (
    .clk       (clk),
    .reset_i   (reset_i),
    .req_i     (req_i),
    .busy_i    (busy_o),
    .done_i    (done_o),
    .err_i     (err_o),
    .hit_i     (hit_o),
    .hit_acc_i (hit_acc),
    .mem_rd_i  (mem_rd_o),
    .fill_i    (fill_q)
);

//--- tb/l3_mem_subsystem_tb.sv
module l3_mem_subsystem_tb;

    import cache_geom_pkg::*;
    import mem_access_pkg::*;

    localparam int          RESET_CYCLES = 8;
    localparam int          MAX_ACCESSES = 64;
    localparam int          FIELDS       = 6;               // Words per pattern line
    localparam int          DONE_LIMIT   = 16;              // Cycles to see done or err
    localparam int          IDLE_LIMIT   = 16;              // Cycles to see busy drop
    localparam int          HIT_LATENCY  = 1;               // Hit or error answers at T+1
    localparam int          MISS_LATENCY = 2;               // Miss answers at T+2
    localparam logic [31:0] SEED         = 32'hdefb_e531;

    // Operation column
    localparam logic [31:0] OP_READ  = 32'h0;
    localparam logic [31:0] OP_WRITE = 32'h1;
    localparam logic [31:0] OP_RESET = 32'h2;
    localparam logic [31:0] OP_END   = 32'hffff_ffff;      // Entries the file left empty

    // Result column, anything else means miss
    localparam logic [31:0] RES_HIT = 32'h1;
    localparam logic [31:0] RES_ERR = 32'h2;

    logic                  clk;
    logic                  reset_i;
    logic                  req_i;
    logic                  wr_i;
    size_code_t            size_i;
    logic [ADDR_WIDTH-1:0] addr_i;
    logic [DATA_WIDTH-1:0] wdata_i;
    logic                  done_o;
    logic                  hit_o;
    logic                  err_o;
    logic [DATA_WIDTH-1:0] rdata_o;
    logic                  busy_o;

    // op, size, addr, wdata, expected data, expected result
    logic [31:0] patterns [MAX_ACCESSES*FIELDS];

    l3_mem_subsystem uut (
        .clk     (clk),
        .reset_i (reset_i),
        .req_i   (req_i),
        .wr_i    (wr_i),
        .size_i  (size_i),
        .addr_i  (addr_i),
        .wdata_i (wdata_i),
        .done_o  (done_o),
        .hit_o   (hit_o),
        .err_o   (err_o),
        .rdata_o (rdata_o),
        .busy_o  (busy_o)
    );

    always #5 clk = ~clk;    // 10-unit period

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("Test failed");
        $fatal(1, "Simulation stopped after a failure");
    endtask

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            stop_with_failure($sformatf("CHECK FAILED at time %0t: %s, got %h, expected %h",
                                        $time, what, actual, expected));
        end
    endtask

    // Assertion failures in the bound checker end the run too
    always @(negedge clk) begin
        if (uut.u_cache.u_chk.fail_count != 0) begin
            stop_with_failure("A bound assertion on the cache failed");
        end
    end

    task automatic apply_reset();
        reset_i <= 1'b1;
        req_i   <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset_i <= 1'b0;
        @(negedge clk);
        check_value(32'(done_o), 32'h0, "done_o after reset");
        check_value(32'(err_o), 32'h0, "err_o after reset");
        check_value(32'(busy_o), 32'h0, "busy_o after reset");
    endtask

    // Sampled on falling edges, away from the DUT updates
    // Latency counts cycles after the request cycle
    task automatic wait_for_completion(input string label, output int latency);
        int cycles;
        cycles = 1;
        @(negedge clk);
        while (!done_o && !err_o) begin
            check_value(32'(busy_o), 32'h1, {label, ", busy_o before completion"});
            cycles++;
            if (cycles > DONE_LIMIT) begin
                stop_with_failure({"Timeout: neither done_o nor err_o arrived for ", label});
            end
            @(negedge clk);
        end
        latency = cycles;
    endtask

    task automatic wait_until_idle(input string label);
        int cycles;
        cycles = 0;
        while (busy_o) begin
            cycles++;
            if (cycles > IDLE_LIMIT) begin
                stop_with_failure({"Timeout: busy_o stayed high after ", label});
            end
            @(negedge clk);
        end
    endtask

    initial begin
        int          base;
        int          gap;
        int          latency;
        logic [31:0] op;
        logic [31:0] exp_result;
        string       label;

        clk     = 1'b0;
        reset_i = 1'b1;
        req_i   = 1'b0;
        wr_i    = 1'b0;
        size_i  = SIZE_WORD;
        addr_i  = '0;
        wdata_i = '0;
        void'($urandom(SEED));    // Fixed seed for the idle gaps

        for (int i = 0; i < MAX_ACCESSES*FIELDS; i++) begin
            patterns[i] = OP_END;
        end
        $readmemh("tb/access_patterns.hex", patterns);
        if (patterns[0] == OP_END) begin
            stop_with_failure("No access patterns could be read from tb/access_patterns.hex");
        end

        apply_reset();

        for (int n = 0; n < MAX_ACCESSES; n++) begin
            base = n * FIELDS;
            op   = patterns[base];
            if (op == OP_END) break;
            label = $sformatf("access %0d to %h", n, patterns[base+2]);
            if (op == OP_RESET) begin
                @(posedge clk);
                apply_reset();
            end else if (op == OP_READ || op == OP_WRITE) begin
                @(posedge clk);
                req_i   <= 1'b1;
                wr_i    <= (op == OP_WRITE);
                size_i  <= size_code_t'(patterns[base+1]);
                addr_i  <= patterns[base+2];
                wdata_i <= patterns[base+3];
                @(posedge clk);
                req_i   <= 1'b0;    // One-cycle strobe
                wait_for_completion(label, latency);
                exp_result = patterns[base+5];
                check_value(32'(latency),
                            (exp_result == RES_ERR || exp_result == RES_HIT) ?
                                32'(HIT_LATENCY) : 32'(MISS_LATENCY),
                            {label, ", cycles to completion"});
                if (exp_result == RES_ERR) begin
                    check_value(32'(err_o), 32'h1, {label, ", err_o"});
                    check_value(32'(done_o), 32'h0, {label, ", done_o"});
                end else begin
                    check_value(32'(done_o), 32'h1, {label, ", done_o"});
                    check_value(32'(err_o), 32'h0, {label, ", err_o"});
                    check_value(32'(hit_o), 32'(exp_result == RES_HIT), {label, ", hit_o"});
                    if (op == OP_READ) begin
                        check_value(rdata_o, patterns[base+4], {label, ", rdata_o"});
                    end
                end
                wait_until_idle(label);
                gap = int'($urandom % 4);    // Idle cycles before the next access
                repeat (gap) @(posedge clk);
            end else begin
                stop_with_failure($sformatf("Unknown operation %h in pattern line %0d", op, n));
            end
        end

        @(negedge clk);
        if (uut.u_cache.u_chk.fail_count == 0) begin
            $display("Test passed");
            $finish;
        end else begin
            stop_with_failure("A bound assertion on the cache failed");
        end
    end

endmodule

//--- tb/access_patterns.hex
// op (0 read, 1 write, 2 reset)  size  address  write data  expected read data
// expected result (0 miss, 1 hit, 2 error); read data is checked on reads only
// Writes of each size to fresh lines
1 f 00000100 a1b2c3d4 00000000 0
1 3 00000204 12345678 00000000 0
1 1 00000308 deadbeef 00000000 0
0 f 00000100 00000000 a1b2c3d4 1
0 f 00000204 00000000 00005678 1
0 f 00000308 00000000 000000ef 1
1 1 00000100 000000ee 00000000 1
1 3 00000100 ffff9988 00000000 1
0 f 00000100 00000000 a1b29988 1
// Narrow reads of a hit line
0 1 00000100 00000000 00000088 1
0 3 00000100 00000000 00009988 1
0 1 00000204 00000000 00000078 1
0 3 00000103 00000000 00009988 1
// Nine tags in set 0x10
1 f 00000040 c0de0000 00000000 0
1 f 00000440 c0de0001 00000000 0
1 f 00000840 c0de0002 00000000 0
1 f 00000c40 c0de0003 00000000 0
1 f 00001040 c0de0004 00000000 0
1 f 00001440 c0de0005 00000000 0
1 f 00001840 c0de0006 00000000 0
1 f 00001c40 c0de0007 00000000 0
1 f 00002040 c0de0008 00000000 0
0 f 00000040 00000000 c0de0000 0
// Hit on the oldest way moves the next eviction
0 f 00000840 00000000 c0de0002 1
0 f 00000440 00000000 c0de0001 0
0 f 00000840 00000000 c0de0002 1
0 f 00000c40 00000000 c0de0003 0
0 f 00001040 00000000 c0de0004 0
0 f 00002040 00000000 c0de0008 1
0 3 00001c40 00000000 00000007 1
// Unsupported size changes nothing
1 5 00000100 11111111 00000000 2
0 f 00000100 00000000 a1b29988 1
0 5 00000500 00000000 00000000 2
0 f 00000500 00000000 00000000 0
// Reset empties the cache, memory keeps its data
2 0 00000000 00000000 00000000 0
0 f 00000100 00000000 a1b29988 0
0 f 00000840 00000000 c0de0002 0
0 3 00000204 00000000 00005678 0
0 f 00000100 00000000 a1b29988 1
0 1 00000308 00000000 000000ef 0
1 f 00000308 0badf00d 00000000 1
0 f 00000308 00000000 0badf00d 1

//--- project.f
src/cache_geom_pkg.sv
src/mem_access_pkg.sv
src/lru_age_tracker.sv
src/l3_set_assoc_cache.sv
src/main_memory.sv
src/l3_mem_subsystem.sv
tb/l3_cache_chk.sv
tb/l3_mem_subsystem_tb.sv

//--- Makefile
TOOL      = verilator
FLAGS     = --binary --timing --assert
TOP       = l3_mem_subsystem_tb
FILE_LIST = project.f
BUILD_DIR = obj_dir
SIM_ARGS  = +verilator+error+limit+100
PASS_TEXT = Test passed

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: compile
	@out="$$(./$(SIM_BIN) $(SIM_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
